// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := riscv_v_logic_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
riscv_v_pkg.sv
riscv_v_alu_pkg.sv
riscv_v_operand_issue.sv
riscv_v_operand_fifo.sv
riscv_v_bitwise.sv
riscv_v_shifter.sv
riscv_v_logic_alu.sv
riscv_v_logic_top.sv
riscv_v_logic_tb.sv

// ==== riscv_v_alu_pkg.sv ====
// Logical unit definitions
// Operation codes, decoded control word, operand bundle and writeback word

package riscv_v_alu_pkg;

    // Operations handled by the logical unit
    typedef enum logic [3:0] {
        OP_AND    = 4'd0,
        OP_OR     = 4'd1,
        OP_XOR    = 4'd2,
        OP_SLL    = 4'd3,
        OP_SRL    = 4'd4,
        OP_SRA    = 4'd5,
        OP_REDAND = 4'd6,
        OP_REDOR  = 4'd7,
        OP_REDXOR = 4'd8
    } logic_op_t;

    // Pre-decoded control, built at issue
    typedef struct packed {
        logic                       is_reduct;
        logic                       is_and;
        logic                       is_or;
        logic                       is_xor;
        logic                       is_shift;
        logic                       is_left;
        logic                       is_arith;
        riscv_v_pkg::osize_vector_t osize_vector;
        riscv_v_pkg::osize_vector_t is_greater_osize_vector;
        riscv_v_pkg::osize_vector_t is_less_osize_vector;
    } alu_ctrl_t;

    // One issued operation
    typedef struct packed {
        alu_ctrl_t                 ctrl;
        riscv_v_pkg::byte_vector_t srca;
        riscv_v_pkg::byte_vector_t srcb;
    } alu_bundle_t;

    // Writeback word
    typedef struct packed {
        logic                      valid;
        riscv_v_pkg::byte_vector_t data;
    } wb_data_t;

endpackage : riscv_v_alu_pkg

// ==== riscv_v_bitwise.sv ====
// Bitwise and/or/xor unit
// Element-wise mode and reduction into element 0

`timescale 1ns/100ps

module riscv_v_bitwise (
    input  riscv_v_alu_pkg::alu_ctrl_t  ctrl,
    input  riscv_v_pkg::byte_vector_t   srca,
    input  riscv_v_pkg::byte_vector_t   srcb,
    output riscv_v_pkg::byte_vector_t   result
);
    import riscv_v_pkg::*;

    localparam int HALF = RISCV_V_VLEN / 2;

    logic [RISCV_V_VLEN-1:0] elem_result;
    logic [HALF-1:0]         fold_64;
    logic [HALF-1:0]         fold_32;
    logic [HALF-1:0]         fold_16;
    logic [HALF-1:0]         fold_8;
    logic [HALF-1:0]         elem0_mask;
    logic [HALF-1:0]         red_result;

    // Zero when no op flag is set
    function automatic logic [RISCV_V_VLEN-1:0] apply_op(
        input logic                    is_and,
        input logic                    is_or,
        input logic                    is_xor,
        input logic [RISCV_V_VLEN-1:0] a,
        input logic [RISCV_V_VLEN-1:0] b
    );
        return ((a & b) & {RISCV_V_VLEN{is_and}}) |
               ((a | b) & {RISCV_V_VLEN{is_or}})  |
               ((a ^ b) & {RISCV_V_VLEN{is_xor}});
    endfunction

    assign elem_result = apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor, srca, srcb);

    // Halving tree, each level folds only if the active width is narrower
    always_comb begin
        fold_64 = HALF'(apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor,
                                 RISCV_V_VLEN'(srca[RISCV_V_BYTES-1 -: 8]),
                                 RISCV_V_VLEN'(srca[RISCV_V_BYTES/2-1:0])));
        fold_32 = fold_64;
        if (ctrl.is_greater_osize_vector[3]) begin
            fold_32 = HALF'(apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor,
                                     RISCV_V_VLEN'(fold_64[63:32]),
                                     RISCV_V_VLEN'(fold_64[31:0])));
        end
        fold_16 = fold_32;
        if (ctrl.is_greater_osize_vector[2]) begin
            fold_16 = HALF'(apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor,
                                     RISCV_V_VLEN'(fold_32[31:16]),
                                     RISCV_V_VLEN'(fold_32[15:0])));
        end
        fold_8 = fold_16;
        if (ctrl.is_greater_osize_vector[1]) begin
            fold_8 = HALF'(apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor,
                                    RISCV_V_VLEN'(fold_16[15:8]),
                                    RISCV_V_VLEN'(fold_16[7:0])));
        end
    end

    // Bytes of element 0 at the active width
    assign elem0_mask = {{32{ctrl.is_less_osize_vector[2]}},
                         {16{ctrl.is_less_osize_vector[1]}},
                         {8{ctrl.is_less_osize_vector[0]}},
                         8'hff};

    assign red_result = HALF'(apply_op(ctrl.is_and, ctrl.is_or, ctrl.is_xor,
                                       RISCV_V_VLEN'(fold_8),
                                       RISCV_V_VLEN'(srcb[RISCV_V_BYTES/2-1:0])))
                        & elem0_mask;

    assign result = ctrl.is_reduct ? {{HALF{1'b0}}, red_result} : elem_result;

endmodule : riscv_v_bitwise

// ==== riscv_v_logic_alu.sv ====
// Logical ALU stage
// Pops the FIFO head, merges unit outputs and registers writeback

`timescale 1ns/100ps

module riscv_v_logic_alu (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hold,
    input  logic                          not_empty,
    input  riscv_v_alu_pkg::alu_bundle_t  head,
    output logic                          pop,
    output riscv_v_alu_pkg::wb_data_t     result
);
    import riscv_v_pkg::*;

    byte_vector_t bw_result;
    byte_vector_t sh_result;
    byte_vector_t data_q;
    logic         valid_q;

    assign pop = not_empty & ~hold;

    riscv_v_bitwise u_bitwise (
        .ctrl   (head.ctrl),
        .srca   (head.srca),
        .srcb   (head.srcb),
        .result (bw_result)
    );

    riscv_v_shifter u_shifter (
        .ctrl   (head.ctrl),
        .srca   (head.srca),
        .srcb   (head.srcb),
        .result (sh_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop;
        end
    end

    // Only one unit drives nonzero data
    always_ff @(posedge clk) begin
        if (pop) begin
            data_q <= bw_result | sh_result;
        end
    end

    assign result.valid = valid_q;
    assign result.data  = data_q;

endmodule : riscv_v_logic_alu

// ==== riscv_v_logic_tb.sv ====
// Testbench for the vector logical unit
// Reference model, expected queue with compare process, directed and random tests

`timescale 1ns/100ps

module riscv_v_logic_tb;
    import riscv_v_pkg::*;
    import riscv_v_alu_pkg::*;

    localparam int DEPTH       = 4;
    localparam int N_RAND      = 200;
    // Three directed groups of 36 ops plus the hold, overflow and random tests
    localparam int TOTAL_OPS   = 3 * 36 + DEPTH + DEPTH + 1 + N_RAND;
    localparam int WATCHDOG_NS = (TOTAL_OPS + 50) * 8 * 4;

    logic         clk = 1'b0;
    logic         rst;
    logic         in_valid;
    logic_op_t    in_op;
    sew_t         in_sew;
    byte_vector_t in_srca;
    byte_vector_t in_srcb;
    logic         hold;
    wb_data_t     result;
    logic         overflow;

    int           seed;
    int           cyc = 0;
    int           errors = 0;
    int           pass_tests = 0;
    int           fail_tests = 0;
    int           rx_count = 0;
    logic         lat_check = 1'b0;
    wb_data_t     exp_q[$];
    int           cyc_q[$];
    wb_data_t     exp_w;
    int           issue_c;

    riscv_v_logic_top #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_sew   (in_sew),
        .in_srca  (in_srca),
        .in_srcb  (in_srcb),
        .hold     (hold),
        .result   (result),
        .overflow (overflow)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected writeback computed one element at a time
    function automatic wb_data_t ref_logic(input logic_op_t op, input sew_t sew,
                                           input byte_vector_t a, input byte_vector_t b);
        wb_data_t     r;
        logic [127:0] fa;
        logic [127:0] fb;
        logic [127:0] fr;
        logic [63:0]  mask;
        logic [63:0]  ea;
        logic [63:0]  eb;
        logic [63:0]  er;
        logic [63:0]  acc;
        int           w;
        int           amt;
        fa = a;
        fb = b;
        fr = '0;
        w = 8 << sew;
        mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
        // Reductions start from element 0 of srcb
        acc = 64'(fb) & mask;
        for (int e = 0; e < 128 / w; e++) begin
            ea = 64'(fa >> (e * w)) & mask;
            eb = 64'(fb >> (e * w)) & mask;
            amt = int'(eb[5:0]) & (w - 1);
            er = '0;
            case (op)
                OP_AND:    er = ea & eb;
                OP_OR:     er = ea | eb;
                OP_XOR:    er = ea ^ eb;
                OP_SLL:    er = (ea << amt) & mask;
                OP_SRL:    er = ea >> amt;
                OP_SRA: begin
                    er = ea >> amt;
                    // Negative elements fill the vacated top bits with ones
                    if (ea[w-1]) er = er | (mask & ~(mask >> amt));
                end
                OP_REDAND: acc = acc & ea;
                OP_REDOR:  acc = acc | ea;
                OP_REDXOR: acc = acc ^ ea;
                default:   er = '0;
            endcase
            fr = fr | (128'(er) << (e * w));
        end
        if (op inside {OP_REDAND, OP_REDOR, OP_REDXOR}) fr = 128'(acc);
        r.valid = 1'b1;
        r.data = fr;
        return r;
    endfunction

    function automatic byte_vector_t rand_vec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_wb(input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("FAILED result.data expected %h got %h", exp.data, act.data);
            errors++;
        end
    endtask

    task automatic check_flag(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED overflow expected %h got %h", exp, act);
            errors++;
        end
    endtask

    // Compare process samples on the falling edge
    always @(negedge clk) begin
        if (!rst && result.valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                $display("Unexpected result: result.valid high with nothing outstanding");
                errors++;
            end else begin
                exp_w = exp_q.pop_front();
                issue_c = cyc_q.pop_front();
                check_wb(exp_w, result);
                if (lat_check && (cyc - issue_c) != 3) begin
                    $display("Wrong latency: result came %0d cycles after in_valid, not 3",
                             cyc - issue_c);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic do_reset();
        rst = 1'b1;
        in_valid = 1'b0;
        hold = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Entered and left one step after a rising edge
    task automatic issue_op(input logic_op_t op, input sew_t sew, input byte_vector_t a,
                            input byte_vector_t b, input logic expect_out);
        in_valid = 1'b1;
        in_op = op;
        in_sew = sew;
        in_srca = a;
        in_srcb = b;
        if (expect_out) begin
            exp_q.push_back(ref_logic(op, sew, a, b));
            cyc_q.push_back(cyc);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic issue_random(input logic expect_out);
        logic_op_t op;
        sew_t      sew;
        op = logic_op_t'(4'($unsigned($random(seed)) % 9));
        sew = sew_t'(2'($random(seed)));
        issue_op(op, sew, rand_vec(), rand_vec(), expect_out);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Missing results: %0d operations never came back", exp_q.size());
            errors++;
            exp_q.delete();
            cyc_q.delete();
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name, input int start_err);
        if (errors == start_err) begin
            pass_tests++;
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", name, errors - start_err);
        end
    endtask

    // Per element the shift amount cycles through 0, SEW-1 and a set bit above log2(SEW)
    task automatic shift_operands(input sew_t sew, input int rep,
                                  output byte_vector_t a, output byte_vector_t b);
        logic [127:0] fa;
        logic [127:0] fb;
        logic [63:0]  ev;
        int           w;
        w = 8 << sew;
        fa = rand_vec();
        fb = '0;
        for (int e = 0; e < 128 / w; e++) begin
            ev = {$random(seed), $random(seed)};
            case ((e + rep) % 3)
                0:       ev = ev & ~64'(w - 1);
                1:       ev = ev | 64'(w - 1);
                default: ev = ev | 64'(w);
            endcase
            if (w < 64) ev = ev & ((64'd1 << w) - 64'd1);
            fb = fb | (128'(ev) << (e * w));
            // Even elements negative
            if (e % 2 == 0) fa = fa | (128'(64'd1 << (w - 1)) << (e * w));
        end
        a = fa;
        b = fb;
    endtask

    // Three ops from base at every SEW with three operand sets each issued back to back
    task automatic run_op_group(input logic_op_t base, input string name);
        byte_vector_t a;
        byte_vector_t b;
        logic_op_t    op;
        sew_t         sew;
        int           start_err;
        start_err = errors;
        lat_check = 1'b1;
        for (int k = 0; k < 3; k++) begin
            for (int s = 0; s < 4; s++) begin
                for (int rep = 0; rep < 3; rep++) begin
                    op = logic_op_t'(4'(int'(base) + k));
                    sew = sew_t'(2'(s));
                    if (base == OP_SLL) begin
                        shift_operands(sew, rep, a, b);
                    end else begin
                        a = rand_vec();
                        b = rand_vec();
                        if (base == OP_REDAND && rep == 0) a = '1;
                    end
                    issue_op(op, sew, a, b, 1'b1);
                end
            end
        end
        wait_drain();
        lat_check = 1'b0;
        end_test(name, start_err);
    endtask

    task automatic hold_test();
        int start_err;
        int rx_start;
        int n;
        start_err = errors;
        rx_start = rx_count;
        hold = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            issue_random(1'b1);
        end
        repeat (4) @(posedge clk);
        #1;
        if (rx_count != rx_start) begin
            $display("Result appeared while hold was high");
            errors++;
        end
        check_flag(1'b0, overflow);
        hold = 1'b0;
        n = 0;
        while (!result.valid && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!result.valid) begin
            $display("No result came out after hold fell");
            errors++;
        end else begin
            for (int i = 1; i < DEPTH; i++) begin
                @(negedge clk);
                if (!result.valid) begin
                    $display("Held results did not drain on consecutive cycles");
                    errors++;
                end
            end
        end
        wait_drain();
        check_flag(1'b0, overflow);
        end_test("back-pressure with hold", start_err);
    endtask

    task automatic overflow_test();
        int start_err;
        int rx_start;
        start_err = errors;
        rx_start = rx_count;
        hold = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            issue_random(1'b1);
        end
        // This one exceeds the FIFO depth and is dropped
        issue_random(1'b0);
        repeat (3) @(posedge clk);
        #1;
        check_flag(1'b1, overflow);
        hold = 1'b0;
        wait_drain();
        repeat (4) @(posedge clk);
        #1;
        if (rx_count - rx_start != DEPTH) begin
            $display("Expected %0d results after overflow, saw %0d", DEPTH,
                     rx_count - rx_start);
            errors++;
        end
        check_flag(1'b1, overflow);
        end_test("overflow", start_err);
    endtask

    task automatic random_test();
        int start_err;
        int n;
        start_err = errors;
        do_reset();
        check_flag(1'b0, overflow);
        n = 0;
        while (n < N_RAND) begin
            hold = (($random(seed) & 3) == 0);
            // Keep in-flight work within the FIFO so nothing is dropped
            if (exp_q.size() < DEPTH && ($random(seed) & 3) != 0) begin
                issue_random(1'b1);
                n++;
            end else begin
                @(posedge clk);
                #1;
            end
        end
        hold = 1'b0;
        wait_drain();
        check_flag(1'b0, overflow);
        end_test("random stream", start_err);
    endtask

    initial begin
        seed = 32'h7175_5e82;
        rst = 1'b1;
        in_valid = 1'b0;
        in_op = OP_AND;
        in_sew = SEW_8;
        in_srca = '0;
        in_srcb = '0;
        hold = 1'b0;
        do_reset();
        run_op_group(OP_AND, "element-wise bitwise");
        run_op_group(OP_SLL, "shifts");
        run_op_group(OP_REDAND, "reductions");
        hold_test();
        overflow_test();
        random_test();
        $display("Tests passed %0d, failed %0d, check errors %0d", pass_tests, fail_tests,
                 errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : riscv_v_logic_tb

// ==== riscv_v_logic_top.sv ====
// Vector logical unit top level
// Issue stage, operand FIFO and logical ALU

`timescale 1ns/100ps

module riscv_v_logic_top #(
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  riscv_v_alu_pkg::logic_op_t  in_op,
    input  riscv_v_pkg::sew_t           in_sew,
    input  riscv_v_pkg::byte_vector_t   in_srca,
    input  riscv_v_pkg::byte_vector_t   in_srcb,
    input  logic                        hold,
    output riscv_v_alu_pkg::wb_data_t   result,
    output logic                        overflow
);
    import riscv_v_alu_pkg::*;

    alu_bundle_t issue_bundle;
    alu_bundle_t head;
    logic        push;
    logic        pop;
    logic        not_empty;

    riscv_v_operand_issue u_issue (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_sew   (in_sew),
        .in_srca  (in_srca),
        .in_srcb  (in_srcb),
        .push     (push),
        .bundle   (issue_bundle)
    );

    riscv_v_operand_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (issue_bundle),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    riscv_v_logic_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .not_empty (not_empty),
        .head      (head),
        .pop       (pop),
        .result    (result)
    );

endmodule : riscv_v_logic_top

// ==== riscv_v_operand_fifo.sv ====
// Circular FIFO of operand bundles
// Sticky overflow flag on a dropped push

`timescale 1ns/100ps

module riscv_v_operand_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  riscv_v_alu_pkg::alu_bundle_t  push_data,
    input  logic                          pop,
    output riscv_v_alu_pkg::alu_bundle_t  head,
    output logic                          not_empty,
    output logic                          overflow
);
    import riscv_v_alu_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    alu_bundle_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign rd_en     = pop && not_empty;
    // A full buffer still takes a push when the head leaves in the same cycle
    assign wr_en     = push && (!full || rd_en);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Pointers wrap naturally, DEPTH is a power of two
            if (wr_en) wr_ptr <= wr_ptr + PTR_W'(1);
            if (rd_en) rd_ptr <= rd_ptr + PTR_W'(1);
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            if (push && !wr_en) overflow <= 1'b1;
        end
    end

endmodule : riscv_v_operand_fifo

// ==== riscv_v_operand_issue.sv ====
// Operand issue stage
// Decodes op and SEW into the control word, registers the operand bundle

`timescale 1ns/100ps

module riscv_v_operand_issue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  riscv_v_alu_pkg::logic_op_t    in_op,
    input  riscv_v_pkg::sew_t             in_sew,
    input  riscv_v_pkg::byte_vector_t     in_srca,
    input  riscv_v_pkg::byte_vector_t     in_srcb,
    output logic                          push,
    output riscv_v_alu_pkg::alu_bundle_t  bundle
);
    import riscv_v_pkg::*;
    import riscv_v_alu_pkg::*;

    alu_ctrl_t     ctrl_d;
    osize_vector_t osize;

    // One-hot on the active width
    assign osize = osize_vector_t'(1) << in_sew;

    always_comb begin
        ctrl_d = '0;
        ctrl_d.osize_vector = osize;
        // Widths below the active one are the bits under the one-hot bit
        ctrl_d.is_less_osize_vector = osize - osize_vector_t'(1);
        ctrl_d.is_greater_osize_vector = ~(osize | (osize - osize_vector_t'(1)));
        case (in_op)
            OP_AND:    ctrl_d.is_and = 1'b1;
            OP_OR:     ctrl_d.is_or  = 1'b1;
            OP_XOR:    ctrl_d.is_xor = 1'b1;
            OP_SLL: begin
                ctrl_d.is_shift = 1'b1;
                ctrl_d.is_left  = 1'b1;
            end
            OP_SRL:    ctrl_d.is_shift = 1'b1;
            OP_SRA: begin
                ctrl_d.is_shift = 1'b1;
                ctrl_d.is_arith = 1'b1;
            end
            OP_REDAND: begin
                ctrl_d.is_reduct = 1'b1;
                ctrl_d.is_and    = 1'b1;
            end
            OP_REDOR: begin
                ctrl_d.is_reduct = 1'b1;
                ctrl_d.is_or     = 1'b1;
            end
            OP_REDXOR: begin
                ctrl_d.is_reduct = 1'b1;
                ctrl_d.is_xor    = 1'b1;
            end
            default:   ctrl_d.is_and = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            bundle.ctrl <= ctrl_d;
            bundle.srca <= in_srca;
            bundle.srcb <= in_srcb;
        end
    end

endmodule : riscv_v_operand_issue

// ==== riscv_v_pkg.sv ====
// Vector shape definitions for the logical unit
// Slice width, element width encoding and per-width size vectors

package riscv_v_pkg;

    // Width of one vector register slice in bits
    parameter int RISCV_V_VLEN = 128;

    // Bytes per slice
    parameter int RISCV_V_BYTES = RISCV_V_VLEN / 8;

    // Number of supported element widths (8, 16, 32, 64)
    parameter int RISCV_V_NUM_SEW = 4;

    // Element width encoding, SEW = 8 << value
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // One bit per element width
    // Bit 0 is SEW 8, bit 3 is SEW 64
    typedef logic [RISCV_V_NUM_SEW-1:0] osize_vector_t;

    // Slice data viewed as bytes, byte 0 is the least significant
    typedef logic [RISCV_V_BYTES-1:0][7:0] byte_vector_t;

endpackage : riscv_v_pkg

// ==== riscv_v_shifter.sv ====
// Per-element shifter
// Logical left, logical right and arithmetic right at every SEW

`timescale 1ns/100ps

module riscv_v_shifter (
    input  riscv_v_alu_pkg::alu_ctrl_t  ctrl,
    input  riscv_v_pkg::byte_vector_t   srca,
    input  riscv_v_pkg::byte_vector_t   srcb,
    output riscv_v_pkg::byte_vector_t   result
);
    import riscv_v_pkg::*;

    logic [RISCV_V_VLEN-1:0]                      a_flat;
    logic [RISCV_V_VLEN-1:0]                      b_flat;
    logic [RISCV_V_NUM_SEW-1:0][RISCV_V_VLEN-1:0] cand;
    logic [RISCV_V_VLEN-1:0]                      shift_sel;

    assign a_flat = srca;
    assign b_flat = srcb;

    // One candidate slice per element width
    for (genvar g = 0; g < RISCV_V_NUM_SEW; g++) begin : g_sew
        localparam int W  = 8 << g;
        localparam int SH = 3 + g;

        for (genvar e = 0; e < RISCV_V_VLEN / W; e++) begin : g_elem
            logic [W-1:0]        a;
            logic [SH-1:0]       amt;
            logic signed [W-1:0] sra;

            assign a   = a_flat[e*W +: W];
            // Upper bits of the shift element are ignored
            assign amt = b_flat[e*W +: SH];
            assign sra = $signed(a) >>> amt;

            assign cand[g][e*W +: W] = ctrl.is_left  ? (a << amt) :
                                       ctrl.is_arith ? sra        :
                                                       (a >> amt);
        end
    end

    // Pick the candidate of the active width
    always_comb begin
        shift_sel = '0;
        for (int g = 0; g < RISCV_V_NUM_SEW; g++) begin
            if (ctrl.osize_vector[g]) begin
                shift_sel = shift_sel | cand[g];
            end
        end
    end

    assign result = ctrl.is_shift ? shift_sel : '0;

endmodule : riscv_v_shifter
